//--- vlog.f
rtl/mem_pkg.sv
rtl/rsp_rr_arbiter.sv
rtl/mem_axi_bridge.sv
rtl/axi_bank_ram.sv
rtl/mem_subsys_top.sv
verif/tb_clock_gen.sv
verif/mem_subsys_chk.sv
verif/mem_subsys_checker.sv
verif/mem_subsys_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the simulation prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mem_subsys_tb -f vlog.f &&
./obj_dir/Vmem_subsys_tb | tee /dev/stderr | grep -q "All tests passed!" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed or did not build"; exit 1; }

//--- verif/mem_subsys_tb.sv
// Testbench top for the banked memory subsystem; run as the simulation top module
`timescale 1ns/1ns

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int NUM_BANKS   = 2;
    localparam int RAM_DEPTH   = 64;
    localparam int WORDS       = NUM_BANKS * RAM_DEPTH;
    localparam int PARTIAL_OPS = 16;
    localparam int RANDOM_OPS  = 400;
    localparam int STALL_CYC   = 10;
    // Reset, idle checks and the stall window are covered by the spare operations
    localparam int TOTAL_OPS   = 2 * WORDS + 2 * PARTIAL_OPS + NUM_BANKS + RANDOM_OPS + 16;
    localparam int CYCLE_LIMIT = TOTAL_OPS * 20;

    logic              clk;
    logic              reset;
    logic              mem_req_valid;
    mem_req_t          mem_req;
    logic              mem_req_ready;
    logic              mem_rsp_valid;
    mem_rsp_t          mem_rsp;
    logic              mem_rsp_ready;

    int                req_count;
    int                rsp_count;
    int                err_count;
    logic [(1 << TAG_W)-1:0] pending;

    // 0 ready high, 1 ready low, 2 ready random
    logic [1:0]        rdy_mode;
    logic              rdy_bit = 1'b1;
    logic [31:0]       rdy_rng = 32'd90694;
    logic [31:0]       stim_rng = 32'd90694;

    logic [TAG_W-1:0]  next_tag;
    logic [31:0]       r;
    logic [WADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    mem_rsp_t          held_rsp;
    int                tb_errors;
    int                tests_run;
    int                tests_failed;
    int                errs_before;
    int                rsp_before;
    int                cycles = 0;

    tb_clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (8)
    ) u_clk (
        .clk   (clk),
        .reset (reset)
    );

    mem_subsys_top #(
        .NUM_BANKS (NUM_BANKS),
        .RAM_DEPTH (RAM_DEPTH)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    mem_subsys_checker #(
        .NUM_BANKS (NUM_BANKS),
        .RAM_DEPTH (RAM_DEPTH)
    ) u_checker (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .req_count     (req_count),
        .rsp_count     (rsp_count),
        .err_count     (err_count),
        .pending       (pending)
    );

    bind mem_axi_bridge mem_subsys_chk #(
        .NUM_BANKS (NUM_BANKS)
    ) u_chk (
        .clk           (clk),
        .reset         (reset),
        .aw_valid      (aw_valid),
        .aw            (aw),
        .aw_ready      (aw_ready),
        .w_valid       (w_valid),
        .w             (w),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .b             (b),
        .ar_valid      (ar_valid),
        .ar            (ar),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r             (r),
        .r_ready       (r_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    // Every word gets a distinct value built from its full address
    function automatic logic [DATA_W-1:0] fill_word(input int unsigned a);
        logic [15:0] h;
        h = 16'(a);
        return {h ^ 16'hC3A5, ~h, h * 16'd7, h};
    endfunction

    assign mem_rsp_ready = (rdy_mode == 2'd2) ? rdy_bit : (rdy_mode == 2'd0);

    always @(negedge clk) begin
        rdy_rng = xorshift32(rdy_rng);
        rdy_bit = rdy_rng[7];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // Called on a falling edge; returns on the falling edge after the handshake
    task automatic send_req(input logic rw, input logic [STRB_W-1:0] be,
                            input logic [WADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                            input logic [TAG_W-1:0] t);
        int start;
        start = req_count;
        mem_req = '{rw: rw, byteen: be, addr: a, data: d, tag: t};
        mem_req_valid = 1'b1;
        do @(negedge clk); while (req_count == start);
        mem_req_valid = 1'b0;
    endtask

    task automatic write_word(input logic [WADDR_W-1:0] a, input logic [STRB_W-1:0] be,
                              input logic [DATA_W-1:0] d);
        send_req(1'b1, be, a, d, '0);
    endtask

    // Tags rotate through all 16; wait while the next one is still out
    task automatic read_word(input logic [WADDR_W-1:0] a);
        while (pending[next_tag]) @(negedge clk);
        send_req(1'b0, '0, a, '0, next_tag);
        next_tag = next_tag + 1'b1;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (pending != '0 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (pending != '0) begin
            $display("t=%0t read responses lost, tags %h still outstanding", $time, pending);
            tb_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int total;
        total = err_count + tb_errors;
        tests_run++;
        if (total == errs_before) begin
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, total - errs_before);
        end
        errs_before = total;
    endtask

    initial begin
        mem_req_valid = 1'b0;
        mem_req       = '0;
        rdy_mode      = 2'd0;
        next_tag      = '0;
        tb_errors     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errs_before   = 0;
        @(negedge clk);
        while (reset) @(negedge clk);

        // Idle port after reset
        repeat (3) begin
            if (mem_rsp_valid !== 1'b0) begin
                $display("t=%0t mem_rsp_valid is high after reset with no read issued", $time);
                tb_errors++;
            end
            if (mem_req_ready !== 1'b0) begin
                $display("t=%0t mem_req_ready is high while no request is valid", $time);
                tb_errors++;
            end
            @(negedge clk);
        end
        finish_test("reset_idle");

        // Full-strobe fill of every word in every bank, then read back
        for (int a = 0; a < WORDS; a++) begin
            write_word(WADDR_W'(a), '1, fill_word(a));
        end
        for (int a = 0; a < WORDS; a++) begin
            read_word(WADDR_W'(a));
        end
        drain();
        finish_test("full_write_read");

        for (int i = 0; i < PARTIAL_OPS; i++) begin
            r    = rand_word();
            addr = WADDR_W'(rand_word() % WORDS);
            data = {rand_word(), rand_word()};
            write_word(addr, r[7:0], data);
            read_word(addr);
        end
        drain();
        finish_test("partial_byte_enables");

        // One read per bank under a stalled response port
        rdy_mode   = 2'd1;
        rsp_before = rsp_count;
        for (int b = 0; b < NUM_BANKS; b++) begin
            read_word(WADDR_W'(b));
        end
        held_rsp = mem_rsp;
        repeat (STALL_CYC) begin
            @(negedge clk);
            if (mem_rsp_valid !== 1'b1) begin
                $display("t=%0t mem_rsp_valid dropped while the response was stalled", $time);
                tb_errors++;
            end else if (mem_rsp !== held_rsp) begin
                $display("MISMATCH t=%0t mem_rsp expected=%h actual=%h",
                         $time, held_rsp, mem_rsp);
                tb_errors++;
            end
        end
        rdy_mode = 2'd0;
        drain();
        if (rsp_count - rsp_before != NUM_BANKS) begin
            $display("t=%0t expected %0d responses after the stall but saw %0d",
                     $time, NUM_BANKS, rsp_count - rsp_before);
            tb_errors++;
        end
        finish_test("response_backpressure");

        rdy_mode = 2'd2;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r    = rand_word();
            addr = WADDR_W'(rand_word() % WORDS);
            if (r[0]) begin
                data = {rand_word(), rand_word()};
                write_word(addr, r[15:8], data);
            end else begin
                read_word(addr);
            end
        end
        rdy_mode = 2'd0;
        drain();
        finish_test("random_traffic");

        $display("Tests run %0d, passed %0d, failed %0d, responses checked %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, rsp_count,
                 err_count + tb_errors);
        if (tests_failed == 0 && err_count + tb_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verif/mem_subsys_checker.sv
// Scoreboard that watches the memory port for the testbench top and compares read responses
`timescale 1ns/1ns

module mem_subsys_checker #(
    parameter int NUM_BANKS = 2,
    parameter int RAM_DEPTH = 64
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 mem_req_valid,
    input  mem_pkg::mem_req_t                    mem_req,
    input  logic                                 mem_req_ready,
    input  logic                                 mem_rsp_valid,
    input  mem_pkg::mem_rsp_t                    mem_rsp,
    input  logic                                 mem_rsp_ready,
    output int                                   req_count,
    output int                                   rsp_count,
    output int                                   err_count,
    output logic [(1 << mem_pkg::TAG_W)-1:0]     pending
);
    import mem_pkg::*;

    localparam int WORDS = NUM_BANKS * RAM_DEPTH;

    logic [DATA_W-1:0] shadow [WORDS];
    logic [DATA_W-1:0] expected [1 << TAG_W];

    // Write reference where only the enabled bytes replace the old word
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [STRB_W-1:0] be);
        logic [DATA_W-1:0] res;
        res = old_word;
        for (int j = 0; j < STRB_W; j++) begin
            if (be[j]) begin
                res[j*8 +: 8] = new_word[j*8 +: 8];
            end
        end
        return res;
    endfunction

    initial begin
        req_count = 0;
        rsp_count = 0;
        err_count = 0;
        pending   = '0;
    end

    // Responses are retired before new requests so a freed tag can be reused
    always @(posedge clk) begin
        if (!reset && mem_rsp_valid && mem_rsp_ready) begin
            rsp_count++;
            if (!pending[mem_rsp.tag]) begin
                $display("t=%0t response with tag %0d arrived but no read is outstanding on it",
                         $time, mem_rsp.tag);
                err_count++;
            end else begin
                if (mem_rsp.data !== expected[mem_rsp.tag]) begin
                    $display("MISMATCH t=%0t mem_rsp.data tag=%0d expected=%h actual=%h",
                             $time, mem_rsp.tag, expected[mem_rsp.tag], mem_rsp.data);
                    err_count++;
                end
                pending[mem_rsp.tag] = 1'b0;
            end
        end
        if (!reset && mem_req_valid && mem_req_ready) begin
            req_count++;
            if (mem_req.rw) begin
                shadow[mem_req.addr] = merge_bytes(shadow[mem_req.addr], mem_req.data,
                                                   mem_req.byteen);
            end else begin
                expected[mem_req.tag] = shadow[mem_req.addr];
                pending[mem_req.tag]  = 1'b1;
            end
        end
    end

endmodule

//--- verif/mem_subsys_chk.sv
// AXI protocol assertions for the bridge, attached to mem_axi_bridge by bind in the testbench
`timescale 1ns/1ns

module mem_subsys_chk #(
    parameter int NUM_BANKS = 2
) (
    input logic                                 clk,
    input logic                                 reset,
    input logic [NUM_BANKS-1:0]                 aw_valid,
    input mem_pkg::axi_ax_t [NUM_BANKS-1:0]     aw,
    input logic [NUM_BANKS-1:0]                 aw_ready,
    input logic [NUM_BANKS-1:0]                 w_valid,
    input mem_pkg::axi_w_t [NUM_BANKS-1:0]      w,
    input logic [NUM_BANKS-1:0]                 w_ready,
    input logic [NUM_BANKS-1:0]                 b_valid,
    input mem_pkg::axi_b_t [NUM_BANKS-1:0]      b,
    input logic [NUM_BANKS-1:0]                 ar_valid,
    input mem_pkg::axi_ax_t [NUM_BANKS-1:0]     ar,
    input logic [NUM_BANKS-1:0]                 ar_ready,
    input logic [NUM_BANKS-1:0]                 r_valid,
    input mem_pkg::axi_r_t [NUM_BANKS-1:0]      r,
    input logic [NUM_BANKS-1:0]                 r_ready,
    input logic                                 mem_rsp_valid,
    input mem_pkg::mem_rsp_t                    mem_rsp,
    input logic                                 mem_rsp_ready
);
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        logic w_owed;

        // Set by an AW transfer and cleared by the W transfer that completes the write
        always_ff @(posedge clk) begin
            if (reset) begin
                w_owed <= 1'b0;
            end else if (w_valid[i] && w_ready[i]) begin
                w_owed <= 1'b0;
            end else if (aw_valid[i] && aw_ready[i]) begin
                w_owed <= 1'b1;
            end
        end

        // A stalled beat keeps valid and payload until it transfers
        a_aw_hold: assert property (@(posedge clk) disable iff (reset)
            aw_valid[i] && !aw_ready[i] |=> aw_valid[i] && $stable(aw[i]))
            else $error("AW valid or payload changed while stalled on bank %0d", i);
        a_w_hold: assert property (@(posedge clk) disable iff (reset)
            w_valid[i] && !w_ready[i] |=> w_valid[i] && $stable(w[i]))
            else $error("W valid or payload changed while stalled on bank %0d", i);
        a_ar_hold: assert property (@(posedge clk) disable iff (reset)
            ar_valid[i] && !ar_ready[i] |=> ar_valid[i] && $stable(ar[i]))
            else $error("AR valid or payload changed while stalled on bank %0d", i);
        a_r_hold: assert property (@(posedge clk) disable iff (reset)
            r_valid[i] && !r_ready[i] |=> r_valid[i] && $stable(r[i]))
            else $error("R valid or payload changed while stalled on bank %0d", i);

        // Only W may follow an address the bank has already taken
        a_aw_once: assert property (@(posedge clk) disable iff (reset)
            w_owed |-> !aw_valid[i])
            else $error("AW presented again before W on bank %0d", i);

        a_r_okay: assert property (@(posedge clk) disable iff (reset)
            r_valid[i] |-> r[i].resp == 2'b00 && r[i].last)
            else $error("R beat on bank %0d has nonzero resp or last low", i);
        a_b_okay: assert property (@(posedge clk) disable iff (reset)
            b_valid[i] |-> b[i].resp == 2'b00)
            else $error("B beat on bank %0d has nonzero resp", i);
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid && !mem_rsp_ready |=> mem_rsp_valid && $stable(mem_rsp))
        else $error("Memory response changed while stalled");

endmodule

//--- verif/tb_clock_gen.sv
// Testbench clock and reset source; instantiated once by the testbench top
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge, like all other stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- rtl/mem_subsys_top.sv
// Banked memory subsystem top: memory-request port in, bridge plus one RAM per bank
`timescale 1ns/1ns

module mem_subsys_top #(
    parameter int NUM_BANKS = 2,
    parameter int RAM_DEPTH = 64
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_req_valid,
    input  mem_pkg::mem_req_t mem_req,
    output logic              mem_req_ready,
    output logic              mem_rsp_valid,
    output mem_pkg::mem_rsp_t mem_rsp,
    input  logic              mem_rsp_ready
);
    import mem_pkg::*;

    logic [NUM_BANKS-1:0]    aw_valid;
    axi_ax_t [NUM_BANKS-1:0] aw;
    logic [NUM_BANKS-1:0]    aw_ready;
    logic [NUM_BANKS-1:0]    w_valid;
    axi_w_t [NUM_BANKS-1:0]  w;
    logic [NUM_BANKS-1:0]    w_ready;
    logic [NUM_BANKS-1:0]    b_valid;
    axi_b_t [NUM_BANKS-1:0]  b;
    logic [NUM_BANKS-1:0]    b_ready;
    logic [NUM_BANKS-1:0]    ar_valid;
    axi_ax_t [NUM_BANKS-1:0] ar;
    logic [NUM_BANKS-1:0]    ar_ready;
    logic [NUM_BANKS-1:0]    r_valid;
    axi_r_t [NUM_BANKS-1:0]  r;
    logic [NUM_BANKS-1:0]    r_ready;

    mem_axi_bridge #(
        .NUM_BANKS (NUM_BANKS)
    ) u_bridge (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .aw_valid      (aw_valid),
        .aw            (aw),
        .aw_ready      (aw_ready),
        .w_valid       (w_valid),
        .w             (w),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .b             (b),
        .b_ready       (b_ready),
        .ar_valid      (ar_valid),
        .ar            (ar),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r             (r),
        .r_ready       (r_ready)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        axi_bank_ram #(
            .RAM_DEPTH (RAM_DEPTH)
        ) u_ram (
            .clk      (clk),
            .reset    (reset),
            .aw_valid (aw_valid[i]),
            .aw       (aw[i]),
            .aw_ready (aw_ready[i]),
            .w_valid  (w_valid[i]),
            .w        (w[i]),
            .w_ready  (w_ready[i]),
            .b_valid  (b_valid[i]),
            .b        (b[i]),
            .b_ready  (b_ready[i]),
            .ar_valid (ar_valid[i]),
            .ar       (ar[i]),
            .ar_ready (ar_ready[i]),
            .r_valid  (r_valid[i]),
            .r        (r[i]),
            .r_ready  (r_ready[i])
        );
    end

endmodule

//--- rtl/axi_bank_ram.sv
// Single-beat AXI4 slave RAM, one instance per memory bank
`timescale 1ns/1ns

module axi_bank_ram #(
    parameter int RAM_DEPTH = 64
) (
    input  logic              clk,
    input  logic              reset,

    input  logic              aw_valid,
    input  mem_pkg::axi_ax_t  aw,
    output logic              aw_ready,

    input  logic              w_valid,
    input  mem_pkg::axi_w_t   w,
    output logic              w_ready,

    output logic              b_valid,
    output mem_pkg::axi_b_t   b,
    input  logic              b_ready,

    input  logic              ar_valid,
    input  mem_pkg::axi_ax_t  ar,
    output logic              ar_ready,

    output logic              r_valid,
    output mem_pkg::axi_r_t   r,
    input  logic              r_ready
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(RAM_DEPTH);

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    logic             aw_held;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_id;
    logic [IDX_W-1:0] rd_idx;
    logic             aw_fire;
    logic             w_fire;
    logic             ar_fire;

    // Byte address back to a word index
    assign rd_idx = ar.addr[AXSIZE +: IDX_W];

    // New AW only when the previous B can leave this cycle
    assign aw_ready = !aw_held && (!b_valid || b_ready);
    assign w_ready  = aw_held;
    assign ar_ready = !r_valid;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign ar_fire = ar_valid && ar_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_held <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_held <= 1'b1;
            end else if (w_fire) begin
                aw_held <= 1'b0;
            end

            if (w_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end

            if (ar_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx <= aw.addr[AXSIZE +: IDX_W];
            wr_id  <= aw.id;
        end
        if (w_fire) begin
            b <= '{id: wr_id, resp: 2'b00};
            for (int j = 0; j < STRB_W; j++) begin
                if (w.strb[j]) begin
                    mem[wr_idx][j*8 +: 8] <= w.data[j*8 +: 8];
                end
            end
        end
        // R register holds until the read is taken
        if (ar_fire) begin
            r <= '{data: mem[rd_idx], id: ar.id, resp: 2'b00, last: 1'b1};
        end
    end

endmodule

//--- rtl/mem_axi_bridge.sv
// Memory-port to multi-bank AXI bridge, instantiated once by the subsystem top
`timescale 1ns/1ns

module mem_axi_bridge #(
    parameter int NUM_BANKS = 2
) (
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                mem_req_valid,
    input  mem_pkg::mem_req_t                   mem_req,
    output logic                                mem_req_ready,

    output logic                                mem_rsp_valid,
    output mem_pkg::mem_rsp_t                   mem_rsp,
    input  logic                                mem_rsp_ready,

    output logic [NUM_BANKS-1:0]                aw_valid,
    output mem_pkg::axi_ax_t [NUM_BANKS-1:0]    aw,
    input  logic [NUM_BANKS-1:0]                aw_ready,

    output logic [NUM_BANKS-1:0]                w_valid,
    output mem_pkg::axi_w_t [NUM_BANKS-1:0]     w,
    input  logic [NUM_BANKS-1:0]                w_ready,

    input  logic [NUM_BANKS-1:0]                b_valid,
    input  mem_pkg::axi_b_t [NUM_BANKS-1:0]     b,
    output logic [NUM_BANKS-1:0]                b_ready,

    output logic [NUM_BANKS-1:0]                ar_valid,
    output mem_pkg::axi_ax_t [NUM_BANKS-1:0]    ar,
    input  logic [NUM_BANKS-1:0]                ar_ready,

    input  logic [NUM_BANKS-1:0]                r_valid,
    input  mem_pkg::axi_r_t [NUM_BANKS-1:0]     r,
    output logic [NUM_BANKS-1:0]                r_ready
);
    import mem_pkg::*;

    localparam int LOG2_NB = $clog2(NUM_BANKS);
    localparam int BANK_W  = (NUM_BANKS > 1) ? LOG2_NB : 1;

    logic [BANK_W-1:0]    bank_sel;
    logic [ADDR_W-1:0]    word_idx;
    logic [ADDR_W-1:0]    axi_addr;
    logic [NUM_BANKS-1:0] aw_acked;
    mem_rsp_t [NUM_BANKS-1:0] arb_rsp;

    if (NUM_BANKS > 1) begin : g_bank_sel
        assign bank_sel = mem_req.addr[BANK_W-1:0];
    end else begin : g_bank_sel_one
        assign bank_sel = '0;
    end

    // Bank bits removed, then scaled to a byte address
    assign word_idx = ADDR_W'(mem_req.addr) >> LOG2_NB;
    assign axi_addr = word_idx << AXSIZE;

    // The request completes on the W or AR transfer of the selected bank
    assign mem_req_ready = mem_req.rw ? (w_valid[bank_sel] && w_ready[bank_sel])
                                      : (ar_valid[bank_sel] && ar_ready[bank_sel]);

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        logic hit;
        assign hit = mem_req_valid && (bank_sel == BANK_W'(i));

        // AW goes first; W follows once the bank has taken the address
        assign aw_valid[i] = hit && mem_req.rw && !aw_acked[i];
        assign aw[i] = '{addr: axi_addr, id: mem_req.tag, len: 8'd0, size: 3'(AXSIZE)};

        assign w_valid[i] = hit && mem_req.rw && aw_acked[i];
        assign w[i] = '{data: mem_req.data, strb: mem_req.byteen, last: 1'b1};

        assign ar_valid[i] = hit && !mem_req.rw;
        assign ar[i] = '{addr: axi_addr, id: mem_req.tag, len: 8'd0, size: 3'(AXSIZE)};

        // Writes carry no response on the memory port
        assign b_ready[i] = 1'b1;

        assign arb_rsp[i] = '{data: r[i].data, tag: r[i].id};

        always_ff @(posedge clk) begin
            if (reset) begin
                aw_acked[i] <= 1'b0;
            end else if (w_valid[i] && w_ready[i]) begin
                aw_acked[i] <= 1'b0;
            end else if (aw_valid[i] && aw_ready[i]) begin
                aw_acked[i] <= 1'b1;
            end
        end
    end

    rsp_rr_arbiter #(
        .NUM_INPUTS (NUM_BANKS)
    ) u_rsp_arb (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (r_valid),
        .in_rsp    (arb_rsp),
        .in_ready  (r_ready),
        .out_valid (mem_rsp_valid),
        .out_rsp   (mem_rsp),
        .out_ready (mem_rsp_ready)
    );

endmodule

//--- rtl/rsp_rr_arbiter.sv
// Round-robin merge of per-bank read responses onto one valid/ready stream
`timescale 1ns/1ns

module rsp_rr_arbiter #(
    parameter int NUM_INPUTS = 2
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [NUM_INPUTS-1:0]                in_valid,
    input  mem_pkg::mem_rsp_t [NUM_INPUTS-1:0]   in_rsp,
    output logic [NUM_INPUTS-1:0]                in_ready,
    output logic                                 out_valid,
    output mem_pkg::mem_rsp_t                    out_rsp,
    input  logic                                 out_ready
);
    localparam int SEL_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

    logic [SEL_W-1:0] ptr;
    logic             locked;
    logic [SEL_W-1:0] lock_sel;
    logic [SEL_W-1:0] rr_sel;
    logic             found;
    logic [SEL_W-1:0] grant_sel;

    // First valid input at or after the priority pointer
    always_comb begin
        int idx;
        found  = 1'b0;
        rr_sel = '0;
        for (int k = 0; k < NUM_INPUTS; k++) begin
            idx = (int'(ptr) + k) % NUM_INPUTS;
            if (!found && in_valid[idx]) begin
                found  = 1'b1;
                rr_sel = SEL_W'(idx);
            end
        end
    end

    // A stalled grant stays put so the output payload holds still
    assign grant_sel = locked ? lock_sel : rr_sel;
    assign out_valid = locked ? in_valid[lock_sel] : found;
    assign out_rsp   = in_rsp[grant_sel];

    always_comb begin
        in_ready = '0;
        in_ready[grant_sel] = out_valid && out_ready;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr      <= '0;
            locked   <= 1'b0;
            lock_sel <= '0;
        end else if (out_valid && out_ready) begin
            locked <= 1'b0;
            // Winner drops to lowest priority
            ptr    <= (grant_sel == SEL_W'(NUM_INPUTS - 1)) ? '0 : grant_sel + 1'b1;
        end else if (out_valid) begin
            locked   <= 1'b1;
            lock_sel <= grant_sel;
        end
    end

endmodule

//--- rtl/mem_pkg.sv
// Shared widths and channel structs for the memory port and the per-bank AXI links
package mem_pkg;

    localparam int DATA_W  = 64;
    localparam int STRB_W  = DATA_W / 8;
    localparam int TAG_W   = 4;
    localparam int WADDR_W = 13;
    localparam int ADDR_W  = 16;
    localparam int AXSIZE  = 3;

    // Request on the memory port, addr counts words
    typedef struct packed {
        logic               rw;
        logic [STRB_W-1:0]  byteen;
        logic [WADDR_W-1:0] addr;
        logic [DATA_W-1:0]  data;
        logic [TAG_W-1:0]   tag;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [TAG_W-1:0]  tag;
    } mem_rsp_t;

    // Shared by AW and AR
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [TAG_W-1:0]  id;
        logic [7:0]        len;
        logic [2:0]        size;
    } axi_ax_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [TAG_W-1:0] id;
        logic [1:0]       resp;
    } axi_b_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [TAG_W-1:0]  id;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

endpackage
